/* Bender.yml */
package:
  name: rv_ex

export_include_dirs:
  - include

sources:
  - files:
      - src/rv_ex_pkg.sv
      - src/alu.sv
      - src/csr_array.sv
      - src/exception.sv
      - src/execution.sv
      - src/rv_ex_top.sv
  - target: test
    files:
      - verif/tb_rv_ex.sv

/* flist.f */
+incdir+include
src/rv_ex_pkg.sv
src/alu.sv
src/csr_array.sv
src/exception.sv
src/execution.sv
src/rv_ex_top.sv
verif/tb_rv_ex.sv

/* include/rv_ex_settings.svh */
// rv32i execute stage settings
// reset values for the machine CSRs and the fixed hart id

`ifndef RV_EX_SETTINGS_SVH
`define RV_EX_SETTINGS_SVH

// trap vector after reset, direct mode
`define RV_EX_MTVEC_RESET 32'h0000_0100

// single hart core
`define RV_EX_MHARTID 32'h0000_0000

`endif

/* src/alu.sv */
// rv32i ALU
// shared add/sub, shifts, logic ops and set-less-than, with branch compare flags

`timescale 1ns/1ps

module alu
	import rv_ex_pkg::*;
(
	input  logic [31:0] a,
	input  logic [31:0] b,
	input  alu_fn_e     fn,
	input  logic        alt,
	output logic [31:0] res,
	output logic        lt,
	output logic        ltu,
	output logic        eq
);

	logic        sub;
	logic [31:0] b_inv;
	logic [31:0] sum;
	logic [4:0]  shamt;
	logic [31:0] sll_res;
	logic [31:0] sr_res;

	// one adder, sub by inverting b and carrying in
	assign sub   = alt && (fn == fn_add);
	assign b_inv = b ^ {32{sub}};
	assign sum   = a + b_inv + {31'd0, sub};

	// compares always see the raw operands
	assign lt  = $signed(a) < $signed(b);
	assign ltu = a < b;
	assign eq  = a == b;

	assign shamt   = b[4:0];
	assign sll_res = a << shamt;

	// alt picks sra over srl
	assign sr_res = alt ? 32'($signed(a) >>> shamt) : a >> shamt;

	always_comb begin
		case (fn)
			fn_add: begin
				res = sum;
			end
			fn_sll: begin
				res = sll_res;
			end
			fn_slt: begin
				res = {31'd0, lt};
			end
			fn_sltu: begin
				res = {31'd0, ltu};
			end
			fn_xor: begin
				res = a ^ b;
			end
			fn_sr: begin
				res = sr_res;
			end
			fn_or: begin
				res = a | b;
			end
			default: begin
				res = a & b;
			end
		endcase
	end

endmodule

/* src/csr_array.sv */
// machine-mode CSR file
// csr read-modify-write plus mepc/mcause/mstatus updates on trap and mret

`timescale 1ns/1ps

`include "rv_ex_settings.svh"

module csr_array
	import rv_ex_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        ex_valid,
	input  ex_op_e      op_ex,
	input  logic [2:0]  funct3_ex,
	input  logic [11:0] csr_adr_ex,
	input  logic [4:0]  csr_uimm_ex,
	input  logic [31:0] rs1_data_ex,
	input  logic [31:0] pc_ex,
	input  logic        trap_ex,
	input  trap_cause_e cause_ex,
	output logic [31:0] csr_rdata,
	output logic        csr_bad_ex,
	output logic [31:0] mtvec,
	output logic [31:0] mepc
);

	// mstatus keeps only MIE and MPIE
	logic        mstatus_mie_q;
	logic        mstatus_mpie_q;
	logic [31:0] mie_q;
	logic [31:0] mtvec_q;
	logic [31:0] mscratch_q;
	logic [31:0] mepc_q;
	logic [31:0] mcause_q;

	logic        csr_act;
	logic        mret_ex;
	logic        adr_ok;
	logic        adr_ro;
	csr_op_e     csr_fn;
	logic [31:0] src;
	logic        wr_req;
	logic [31:0] wdata;
	logic        csr_we;

	assign csr_act = ex_valid && (op_ex == op_csr);
	assign mret_ex = ex_valid && (op_ex == op_mret);
	assign csr_fn  = csr_op_e'(funct3_ex);

	// immediate forms take the zero-extended uimm
	assign src = funct3_ex[2] ? {27'd0, csr_uimm_ex} : rs1_data_ex;

	// read mux and address decode
	always_comb begin
		adr_ok    = 1'b1;
		adr_ro    = 1'b0;
		csr_rdata = 32'd0;
		case (csr_adr_ex)
			rv_ex_pkg::mstatus: begin
				csr_rdata = {24'd0, mstatus_mpie_q, 3'd0, mstatus_mie_q, 3'd0};
			end
			rv_ex_pkg::mie: begin
				csr_rdata = mie_q;
			end
			rv_ex_pkg::mtvec: begin
				csr_rdata = mtvec_q;
			end
			rv_ex_pkg::mscratch: begin
				csr_rdata = mscratch_q;
			end
			rv_ex_pkg::mepc: begin
				csr_rdata = mepc_q;
			end
			rv_ex_pkg::mcause: begin
				csr_rdata = mcause_q;
			end
			rv_ex_pkg::mhartid: begin
				csr_rdata = `RV_EX_MHARTID;
				adr_ro    = 1'b1;
			end
			default: begin
				adr_ok = 1'b0;
			end
		endcase
	end

	// set/clear with a zero source is a pure read
	always_comb begin
		wr_req = 1'b0;
		wdata  = csr_rdata;
		case (csr_fn)
			csrrw, csrrwi: begin
				wr_req = 1'b1;
				wdata  = src;
			end
			csrrs, csrrsi: begin
				wr_req = src != 32'd0;
				wdata  = csr_rdata | src;
			end
			csrrc, csrrci: begin
				wr_req = src != 32'd0;
				wdata  = csr_rdata & ~src;
			end
			default: begin
				wr_req = 1'b0;
			end
		endcase
	end

	assign csr_bad_ex = csr_act && (!adr_ok || (adr_ro && wr_req));
	assign csr_we     = csr_act && wr_req && !csr_bad_ex;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mstatus_mie_q  <= 1'b0;
			mstatus_mpie_q <= 1'b0;
			mie_q          <= 32'd0;
			mtvec_q        <= `RV_EX_MTVEC_RESET;
			mscratch_q     <= 32'd0;
			mepc_q         <= 32'd0;
			mcause_q       <= 32'd0;
		end else if (trap_ex) begin
			mepc_q         <= pc_ex;
			mcause_q       <= {28'd0, cause_ex};
			mstatus_mpie_q <= mstatus_mie_q;
			mstatus_mie_q  <= 1'b0;
		end else if (mret_ex) begin
			mstatus_mie_q  <= mstatus_mpie_q;
			mstatus_mpie_q <= 1'b1;
		end else if (csr_we) begin
			case (csr_adr_ex)
				rv_ex_pkg::mstatus: begin
					mstatus_mie_q  <= wdata[3];
					mstatus_mpie_q <= wdata[7];
				end
				rv_ex_pkg::mie: begin
					mie_q <= wdata;
				end
				rv_ex_pkg::mtvec: begin
					mtvec_q <= wdata;
				end
				rv_ex_pkg::mscratch: begin
					mscratch_q <= wdata;
				end
				// return address stays word aligned
				rv_ex_pkg::mepc: begin
					mepc_q <= {wdata[31:2], 2'b00};
				end
				rv_ex_pkg::mcause: begin
					mcause_q <= wdata;
				end
				default: begin
				end
			endcase
		end
	end

	assign mtvec = mtvec_q;
	assign mepc  = mepc_q;

	// trap from the arbiter must never coincide with a csr update
	a_trap_no_csr_we: assert property (@(posedge clk) disable iff (!rst_n)
		!(trap_ex && csr_we))
		else $error("csr write in a trapping cycle");

endmodule

/* src/exception.sv */
// synchronous trap arbiter
// decides whether the current instruction traps and with which cause

`timescale 1ns/1ps

module exception
	import rv_ex_pkg::*;
(
	input  logic        ex_valid,
	input  ex_op_e      op_ex,
	input  logic        csr_bad_ex,
	output logic        trap_ex,
	output trap_cause_e cause_ex
);

	logic ecall_req;
	logic illegal_req;

	// bad csr accesses come back from the csr file
	assign ecall_req   = ex_valid && (op_ex == op_ecall);
	assign illegal_req = ex_valid && ((op_ex == op_illegal) || csr_bad_ex);

	// new trap sources get their cause here
	always_comb begin
		trap_ex  = 1'b0;
		cause_ex = cause_illegal;
		if (illegal_req) begin
			trap_ex  = 1'b1;
			cause_ex = cause_illegal;
		end else if (ecall_req) begin
			trap_ex  = 1'b1;
			cause_ex = cause_ecall_m;
		end
	end

	// neither the csr file nor the arbiter may flag anything without a strobe
	always_comb begin
		a_trap_needs_valid: assert final (ex_valid || !(trap_ex || csr_bad_ex))
			else $error("trap or bad csr access without ex_valid");
	end

endmodule

/* src/execution.sv */
// rv32i execute stage core
// operand select, branch resolve, jump target, result mux and memory-stage registers

`timescale 1ns/1ps

module execution
	import rv_ex_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        ex_valid,
	input  ex_op_e      op_ex,
	input  logic [2:0]  funct3_ex,
	input  logic        alt_ex,
	input  logic [31:0] pc_ex,
	input  logic [31:0] imm_ex,
	input  logic [31:0] rs1_data_ex,
	input  logic [31:0] rs2_data_ex,
	input  logic [4:0]  rd_adr_ex,
	input  logic        wbk_rd_ex,
	input  logic [11:0] csr_adr_ex,
	input  logic [4:0]  csr_uimm_ex,
	output logic        jmp_condition_ex,
	output logic [31:0] jmp_adr_ex,
	output logic        trap_taken_ex,
	output logic        cmd_ld_ma,
	output logic        cmd_st_ma,
	output logic        wbk_rd_ma,
	output logic [4:0]  rd_adr_ma,
	output logic [31:0] rd_data_ma,
	output logic [31:0] st_data_ma,
	output logic [2:0]  ldst_code_ma
);

	logic [31:0] alu_b;
	alu_fn_e     alu_fn;
	logic        alu_alt;
	logic [31:0] alu_res;
	logic        lt;
	logic        ltu;
	logic        eq;
	logic        br_cond;
	logic        br_taken;
	logic        trap_ex;
	trap_cause_e cause_ex;
	logic        csr_bad_ex;
	logic [31:0] csr_rdata;
	logic [31:0] csr_mtvec;
	logic [31:0] csr_mepc;
	logic [31:0] pc_imm;
	logic [31:0] rs1_imm;
	logic [31:0] pc_plus4;
	logic [31:0] rd_data_ex;

	// immediate as second operand for op-imm and address calc
	assign alu_b = ((op_ex == op_alui) || (op_ex == op_ld) || (op_ex == op_st)) ?
		imm_ex : rs2_data_ex;

	always_comb begin
		alu_fn  = alu_fn_e'(funct3_ex);
		alu_alt = 1'b0;
		case (op_ex)
			op_ld, op_st: begin
				alu_fn = fn_add;
			end
			op_alu: begin
				alu_alt = alt_ex;
			end
			// only srai uses alt among immediates
			op_alui: begin
				alu_alt = alt_ex && (alu_fn == fn_sr);
			end
			default: begin
			end
		endcase
	end

	alu u_alu (
		.a   (rs1_data_ex),
		.b   (alu_b),
		.fn  (alu_fn),
		.alt (alu_alt),
		.res (alu_res),
		.lt  (lt),
		.ltu (ltu),
		.eq  (eq)
	);

	exception u_exception (
		.ex_valid   (ex_valid),
		.op_ex      (op_ex),
		.csr_bad_ex (csr_bad_ex),
		.trap_ex    (trap_ex),
		.cause_ex   (cause_ex)
	);

	csr_array u_csr_array (
		.clk         (clk),
		.rst_n       (rst_n),
		.ex_valid    (ex_valid),
		.op_ex       (op_ex),
		.funct3_ex   (funct3_ex),
		.csr_adr_ex  (csr_adr_ex),
		.csr_uimm_ex (csr_uimm_ex),
		.rs1_data_ex (rs1_data_ex),
		.pc_ex       (pc_ex),
		.trap_ex     (trap_ex),
		.cause_ex    (cause_ex),
		.csr_rdata   (csr_rdata),
		.csr_bad_ex  (csr_bad_ex),
		.mtvec       (csr_mtvec),
		.mepc        (csr_mepc)
	);

	// branch condition from the compare flags
	always_comb begin
		case (br_fn_e'(funct3_ex))
			br_eq:   br_cond = eq;
			br_ne:   br_cond = !eq;
			br_lt:   br_cond = lt;
			br_ge:   br_cond = !lt;
			br_ltu:  br_cond = ltu;
			br_geu:  br_cond = !ltu;
			default: br_cond = 1'b0;
		endcase
	end

	assign br_taken = (op_ex == op_br) && br_cond;

	assign pc_imm   = pc_ex + imm_ex;
	assign rs1_imm  = rs1_data_ex + imm_ex;
	assign pc_plus4 = pc_ex + 32'd4;

	assign trap_taken_ex    = trap_ex;
	assign jmp_condition_ex = trap_ex || (ex_valid && ((op_ex == op_jal) ||
		(op_ex == op_jalr) || (op_ex == op_mret) || br_taken));

	// trap wins over everything
	always_comb begin
		if (trap_ex) begin
			jmp_adr_ex = {csr_mtvec[31:2], 2'b00};
		end else if (op_ex == op_mret) begin
			jmp_adr_ex = csr_mepc;
		end else if (op_ex == op_jalr) begin
			jmp_adr_ex = {rs1_imm[31:1], 1'b0};
		end else begin
			jmp_adr_ex = pc_imm;
		end
	end

	// ld/st address comes out of the alu adder
	always_comb begin
		case (op_ex)
			op_lui:          rd_data_ex = imm_ex;
			op_auipc:        rd_data_ex = pc_imm;
			op_jal, op_jalr: rd_data_ex = pc_plus4;
			op_csr:          rd_data_ex = csr_rdata;
			default:         rd_data_ex = alu_res;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cmd_ld_ma <= 1'b0;
			cmd_st_ma <= 1'b0;
			wbk_rd_ma <= 1'b0;
		end else begin
			cmd_ld_ma <= ex_valid && !trap_ex && (op_ex == op_ld);
			cmd_st_ma <= ex_valid && !trap_ex && (op_ex == op_st);
			wbk_rd_ma <= ex_valid && !trap_ex && wbk_rd_ex;
		end
	end

	always_ff @(posedge clk) begin
		if (ex_valid) begin
			rd_adr_ma    <= rd_adr_ex;
			rd_data_ma   <= rd_data_ex;
			st_data_ma   <= rs2_data_ex;
			ldst_code_ma <= funct3_ex;
		end
	end

	a_ld_st_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		!(cmd_ld_ma && cmd_st_ma))
		else $error("load and store both issued to memory stage");

endmodule

/* src/rv_ex_pkg.sv */
// rv32i execute stage package
// operation, funct3, CSR address and trap cause encodings

package rv_ex_pkg;

	// decoded instruction class from the decoder
	typedef enum logic [3:0] {
		op_alu,
		op_alui,
		op_lui,
		op_auipc,
		op_ld,
		op_st,
		op_jal,
		op_jalr,
		op_br,
		op_csr,
		op_ecall,
		op_mret,
		op_illegal
	} ex_op_e;

	// funct3 of op / op-imm
	typedef enum logic [2:0] {
		fn_add  = 3'b000,
		fn_sll  = 3'b001,
		fn_slt  = 3'b010,
		fn_sltu = 3'b011,
		fn_xor  = 3'b100,
		fn_sr   = 3'b101,
		fn_or   = 3'b110,
		fn_and  = 3'b111
	} alu_fn_e;

	// funct3 of branches
	typedef enum logic [2:0] {
		br_eq  = 3'b000,
		br_ne  = 3'b001,
		br_lt  = 3'b100,
		br_ge  = 3'b101,
		br_ltu = 3'b110,
		br_geu = 3'b111
	} br_fn_e;

	// funct3 of system csr instructions
	typedef enum logic [2:0] {
		csrrw  = 3'b001,
		csrrs  = 3'b010,
		csrrc  = 3'b011,
		csrrwi = 3'b101,
		csrrsi = 3'b110,
		csrrci = 3'b111
	} csr_op_e;

	// machine csrs implemented here
	typedef enum logic [11:0] {
		mstatus  = 12'h300,
		mie      = 12'h304,
		mtvec    = 12'h305,
		mscratch = 12'h340,
		mepc     = 12'h341,
		mcause   = 12'h342,
		mhartid  = 12'hf14
	} csr_addr_e;

	// synchronous exception codes
	typedef enum logic [3:0] {
		cause_illegal = 4'd2,
		cause_ecall_m = 4'd11
	} trap_cause_e;

endpackage

/* src/rv_ex_top.sv */
// rv32i execute stage top
// stage boundary toward decode, fetch and memory access

`timescale 1ns/1ps

module rv_ex_top
	import rv_ex_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	// from decode
	input  logic        ex_valid,
	input  ex_op_e      op_ex,
	input  logic [2:0]  funct3_ex,
	input  logic        alt_ex,
	input  logic [31:0] pc_ex,
	input  logic [31:0] imm_ex,
	input  logic [31:0] rs1_data_ex,
	input  logic [31:0] rs2_data_ex,
	input  logic [4:0]  rd_adr_ex,
	input  logic        wbk_rd_ex,
	input  logic [11:0] csr_adr_ex,
	input  logic [4:0]  csr_uimm_ex,
	// to fetch
	output logic        jmp_condition_ex,
	output logic [31:0] jmp_adr_ex,
	output logic        trap_taken_ex,
	// to memory access
	output logic        cmd_ld_ma,
	output logic        cmd_st_ma,
	output logic        wbk_rd_ma,
	output logic [4:0]  rd_adr_ma,
	output logic [31:0] rd_data_ma,
	output logic [31:0] st_data_ma,
	output logic [2:0]  ldst_code_ma
);

	execution u_execution (
		.clk              (clk),
		.rst_n            (rst_n),
		.ex_valid         (ex_valid),
		.op_ex            (op_ex),
		.funct3_ex        (funct3_ex),
		.alt_ex           (alt_ex),
		.pc_ex            (pc_ex),
		.imm_ex           (imm_ex),
		.rs1_data_ex      (rs1_data_ex),
		.rs2_data_ex      (rs2_data_ex),
		.rd_adr_ex        (rd_adr_ex),
		.wbk_rd_ex        (wbk_rd_ex),
		.csr_adr_ex       (csr_adr_ex),
		.csr_uimm_ex      (csr_uimm_ex),
		.jmp_condition_ex (jmp_condition_ex),
		.jmp_adr_ex       (jmp_adr_ex),
		.trap_taken_ex    (trap_taken_ex),
		.cmd_ld_ma        (cmd_ld_ma),
		.cmd_st_ma        (cmd_st_ma),
		.wbk_rd_ma        (wbk_rd_ma),
		.rd_adr_ma        (rd_adr_ma),
		.rd_data_ma       (rd_data_ma),
		.st_data_ma       (st_data_ma),
		.ldst_code_ma     (ldst_code_ma)
	);

endmodule

/* verif/tb_rv_ex.sv */
// testbench for the rv32i execute stage
// random instructions from a Galois LFSR, checked against a CSR and datapath model

`timescale 1ns/1ps

`include "rv_ex_settings.svh"

module tb_rv_ex
	import rv_ex_pkg::*;
();

	localparam int CLK_PERIOD     = 20;
	localparam int RESET_CYCLES   = 4;
	localparam int NUM_OPS        = 3000;
	localparam int NUM_DIRECTED   = 24;
	localparam int TIMEOUT_CYCLES = (NUM_OPS + NUM_DIRECTED) * 4 + RESET_CYCLES;

	logic        clk;
	logic        rst_n;
	logic        ex_valid;
	ex_op_e      op_ex;
	logic [2:0]  funct3_ex;
	logic        alt_ex;
	logic [31:0] pc_ex;
	logic [31:0] imm_ex;
	logic [31:0] rs1_data_ex;
	logic [31:0] rs2_data_ex;
	logic [4:0]  rd_adr_ex;
	logic        wbk_rd_ex;
	logic [11:0] csr_adr_ex;
	logic [4:0]  csr_uimm_ex;
	logic        jmp_condition_ex;
	logic [31:0] jmp_adr_ex;
	logic        trap_taken_ex;
	logic        cmd_ld_ma;
	logic        cmd_st_ma;
	logic        wbk_rd_ma;
	logic [4:0]  rd_adr_ma;
	logic [31:0] rd_data_ma;
	logic [31:0] st_data_ma;
	logic [2:0]  ldst_code_ma;

	// model copy of the machine CSRs
	logic        ref_mie_bit;
	logic        ref_mpie_bit;
	logic [31:0] ref_mie;
	logic [31:0] ref_mtvec;
	logic [31:0] ref_mscratch;
	logic [31:0] ref_mepc;
	logic [31:0] ref_mcause;

	// expected memory-stage registers after the next edge
	logic        exp_strobe;
	logic        exp_ld;
	logic        exp_st;
	logic        exp_wbk;
	logic        exp_rd_chk;
	logic [4:0]  exp_rd_adr;
	logic [31:0] exp_rd_data;
	logic [31:0] exp_st_data;
	logic [2:0]  exp_code;

	logic [15:0] lfsr_state = 16'd41745;
	int          errors = 0;
	int          checks = 0;

	rv_ex_top dut (
		.clk              (clk),
		.rst_n            (rst_n),
		.ex_valid         (ex_valid),
		.op_ex            (op_ex),
		.funct3_ex        (funct3_ex),
		.alt_ex           (alt_ex),
		.pc_ex            (pc_ex),
		.imm_ex           (imm_ex),
		.rs1_data_ex      (rs1_data_ex),
		.rs2_data_ex      (rs2_data_ex),
		.rd_adr_ex        (rd_adr_ex),
		.wbk_rd_ex        (wbk_rd_ex),
		.csr_adr_ex       (csr_adr_ex),
		.csr_uimm_ex      (csr_uimm_ex),
		.jmp_condition_ex (jmp_condition_ex),
		.jmp_adr_ex       (jmp_adr_ex),
		.trap_taken_ex    (trap_taken_ex),
		.cmd_ld_ma        (cmd_ld_ma),
		.cmd_st_ma        (cmd_st_ma),
		.wbk_rd_ma        (wbk_rd_ma),
		.rd_adr_ma        (rd_adr_ma),
		.rd_data_ma       (rd_data_ma),
		.st_data_ma       (st_data_ma),
		.ldst_code_ma     (ldst_code_ma)
	);

	initial begin
		clk = 1'b0;
	end

	always #(CLK_PERIOD / 2) clk = ~clk;

	// x^16 + x^14 + x^13 + x^11 + 1, one step per bit
	function automatic logic lfsr_next();
		logic out;
		out = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (out) begin
			lfsr_state = lfsr_state ^ 16'hb400;
		end
		return out;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = 32'd0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_next()};
		end
		return v;
	endfunction

	// zero and sign edges show up often
	function automatic logic [31:0] rand_operand();
		logic [2:0] sel;
		sel = 3'(rand_bits(3));
		case (sel)
			3'd0: return 32'd0;
			3'd1: return 32'h8000_0000;
			3'd2: return 32'h7fff_ffff;
			3'd3: return 32'hffff_ffff;
			default: return rand_bits(32);
		endcase
	endfunction

	function automatic logic [31:0] alu_model(input logic [31:0] a, input logic [31:0] b,
		input logic [2:0] f3, input logic alt);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'd0, $signed(a) < $signed(b)};
			3'd3: return {31'd0, a < b};
			3'd4: return a ^ b;
			3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branch_model(input logic [31:0] a, input logic [31:0] b,
		input logic [2:0] f3);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			3'd7: return a >= b;
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic csr_known(input logic [11:0] adr);
		return adr inside {rv_ex_pkg::mstatus, rv_ex_pkg::mie, rv_ex_pkg::mtvec,
			rv_ex_pkg::mscratch, rv_ex_pkg::mepc, rv_ex_pkg::mcause, rv_ex_pkg::mhartid};
	endfunction

	function automatic logic [31:0] csr_model_read(input logic [11:0] adr);
		case (adr)
			rv_ex_pkg::mstatus: return {24'd0, ref_mpie_bit, 3'd0, ref_mie_bit, 3'd0};
			rv_ex_pkg::mie: return ref_mie;
			rv_ex_pkg::mtvec: return ref_mtvec;
			rv_ex_pkg::mscratch: return ref_mscratch;
			rv_ex_pkg::mepc: return ref_mepc;
			rv_ex_pkg::mcause: return ref_mcause;
			rv_ex_pkg::mhartid: return `RV_EX_MHARTID;
			default: return 32'd0;
		endcase
	endfunction

	// mstatus keeps MIE and MPIE only, mepc stays word aligned
	task automatic csr_model_write(input logic [11:0] adr, input logic [31:0] val);
		case (adr)
			rv_ex_pkg::mstatus: begin
				ref_mie_bit  = val[3];
				ref_mpie_bit = val[7];
			end
			rv_ex_pkg::mie: ref_mie = val;
			rv_ex_pkg::mtvec: ref_mtvec = val;
			rv_ex_pkg::mscratch: ref_mscratch = val;
			rv_ex_pkg::mepc: ref_mepc = {val[31:2], 2'b00};
			rv_ex_pkg::mcause: ref_mcause = val;
			default: begin
			end
		endcase
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp)
		else begin
			errors++;
			$display("Error: %s = %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_registered();
		check_value("cmd_ld_ma", {31'd0, cmd_ld_ma}, {31'd0, exp_ld});
		check_value("cmd_st_ma", {31'd0, cmd_st_ma}, {31'd0, exp_st});
		check_value("wbk_rd_ma", {31'd0, wbk_rd_ma}, {31'd0, exp_wbk});
		if (exp_strobe) begin
			check_value("rd_adr_ma", {27'd0, rd_adr_ma}, {27'd0, exp_rd_adr});
			check_value("st_data_ma", st_data_ma, exp_st_data);
			check_value("ldst_code_ma", {29'd0, ldst_code_ma}, {29'd0, exp_code});
			if (exp_rd_chk) begin
				check_value("rd_data_ma", rd_data_ma, exp_rd_data);
			end
		end
	endtask

	// one cycle: check last results, drive, check jumps, predict and update model
	task automatic issue_instr(input logic v, input ex_op_e op, input logic [2:0] f3,
		input logic alt, input logic [31:0] pc, input logic [31:0] imm,
		input logic [31:0] rs1, input logic [31:0] rs2, input logic [4:0] rd,
		input logic wbk, input logic [11:0] adr, input logic [4:0] uimm);
		logic [31:0] src;
		logic [31:0] old;
		logic [31:0] target;
		logic        wr;
		logic        bad;
		logic        trap;
		logic        jump;
		@(negedge clk);
		check_registered();
		ex_valid    = v;
		op_ex       = op;
		funct3_ex   = f3;
		alt_ex      = alt;
		pc_ex       = pc;
		imm_ex      = imm;
		rs1_data_ex = rs1;
		rs2_data_ex = rs2;
		rd_adr_ex   = rd;
		wbk_rd_ex   = wbk;
		csr_adr_ex  = adr;
		csr_uimm_ex = uimm;
		#(CLK_PERIOD / 4);
		src  = f3[2] ? {27'd0, uimm} : rs1;
		old  = csr_model_read(adr);
		wr   = (f3[1:0] == 2'b01) || (src != 32'd0);
		bad  = (op == op_csr) && (!csr_known(adr) || ((adr == rv_ex_pkg::mhartid) && wr));
		trap = v && (bad || (op == op_ecall) || (op == op_illegal));
		jump = trap || (v && ((op == op_jal) || (op == op_jalr) || (op == op_mret) ||
			((op == op_br) && branch_model(rs1, rs2, f3))));
		if (trap) begin
			target = {ref_mtvec[31:2], 2'b00};
		end else if (op == op_mret) begin
			target = ref_mepc;
		end else if (op == op_jalr) begin
			target = (rs1 + imm) & ~32'd1;
		end else begin
			target = pc + imm;
		end
		check_value("trap_taken_ex", {31'd0, trap_taken_ex}, {31'd0, trap});
		check_value("jmp_condition_ex", {31'd0, jmp_condition_ex}, {31'd0, jump});
		if (jump) begin
			check_value("jmp_adr_ex", jmp_adr_ex, target);
		end
		exp_strobe  = v;
		exp_ld      = v && !trap && (op == op_ld);
		exp_st      = v && !trap && (op == op_st);
		exp_wbk     = v && !trap && wbk;
		exp_rd_adr  = rd;
		exp_st_data = rs2;
		exp_code    = f3;
		exp_rd_chk  = v && !trap && !(op inside {op_br, op_ecall, op_mret, op_illegal});
		case (op)
			op_alu: exp_rd_data = alu_model(rs1, rs2, f3, alt);
			op_alui: exp_rd_data = alu_model(rs1, imm, f3, alt && (f3 == 3'd5));
			op_lui: exp_rd_data = imm;
			op_auipc: exp_rd_data = pc + imm;
			op_jal, op_jalr: exp_rd_data = pc + 32'd4;
			op_csr: exp_rd_data = old;
			default: exp_rd_data = rs1 + imm;
		endcase
		if (trap) begin
			ref_mepc     = pc;
			ref_mcause   = (op == op_ecall) ? 32'd11 : 32'd2;
			ref_mpie_bit = ref_mie_bit;
			ref_mie_bit  = 1'b0;
		end else if (v && (op == op_mret)) begin
			ref_mie_bit  = ref_mpie_bit;
			ref_mpie_bit = 1'b1;
		end else if (v && (op == op_csr) && wr) begin
			case (f3[1:0])
				2'b01: csr_model_write(adr, src);
				2'b10: csr_model_write(adr, old | src);
				default: csr_model_write(adr, old & ~src);
			endcase
		end
	endtask

	// csrrs with x0 is a pure read
	task automatic read_csr(input logic [11:0] adr);
		issue_instr(1'b1, op_csr, 3'b010, 1'b0, 32'h0000_1000, 32'd0, 32'd0, 32'd0,
			5'd7, 1'b1, adr, 5'd0);
	endtask

	task automatic run_trap_sequence();
		issue_instr(1'b1, op_csr, 3'b110, 1'b0, 32'h0000_0ff0, 32'd0, 32'd0, 32'd0,
			5'd0, 1'b0, rv_ex_pkg::mstatus, 5'd8);
		issue_instr(1'b1, op_ecall, 3'b000, 1'b0, 32'h0000_2a40, 32'd0, 32'd0, 32'd0,
			5'd0, 1'b1, 12'd0, 5'd0);
		read_csr(rv_ex_pkg::mepc);
		read_csr(rv_ex_pkg::mcause);
		read_csr(rv_ex_pkg::mstatus);
		issue_instr(1'b1, op_mret, 3'b000, 1'b0, 32'h0000_0104, 32'd0, 32'd0, 32'd0,
			5'd0, 1'b0, 12'd0, 5'd0);
		read_csr(rv_ex_pkg::mstatus);
		// unaligned trap vector
		issue_instr(1'b1, op_csr, 3'b001, 1'b0, 32'h0000_0ff4, 32'd0, 32'h0000_0203,
			32'd0, 5'd3, 1'b1, rv_ex_pkg::mtvec, 5'd0);
		issue_instr(1'b1, op_illegal, 3'b000, 1'b0, 32'h0000_3000, 32'd0, 32'd0, 32'd0,
			5'd4, 1'b1, 12'd0, 5'd0);
		read_csr(rv_ex_pkg::mcause);
		read_csr(rv_ex_pkg::mepc);
		// writing the hart id is illegal
		issue_instr(1'b1, op_csr, 3'b001, 1'b0, 32'h0000_3004, 32'd0, 32'd5, 32'd0,
			5'd5, 1'b1, rv_ex_pkg::mhartid, 5'd0);
		read_csr(rv_ex_pkg::mepc);
		read_csr(rv_ex_pkg::mhartid);
		issue_instr(1'b1, op_csr, 3'b010, 1'b0, 32'h0000_3008, 32'd0, 32'd0, 32'd0,
			5'd6, 1'b1, 12'h7c5, 5'd0);
		read_csr(rv_ex_pkg::mcause);
		read_csr(rv_ex_pkg::mstatus);
	endtask

	task automatic random_instr();
		logic        v;
		logic [3:0]  code;
		ex_op_e      op;
		logic [2:0]  f3;
		logic        alt;
		logic [31:0] pc;
		logic [31:0] imm;
		logic [31:0] a;
		logic [31:0] b;
		logic [4:0]  rd;
		logic        wbk;
		logic [2:0]  sel;
		logic [11:0] adr;
		logic [4:0]  uimm;
		v    = rand_bits(2) != 32'd0;
		code = 4'(rand_bits(4));
		if (code > 4'd12) begin
			code = (code == 4'd15) ? 4'd0 : 4'd9;
		end
		op = ex_op_e'(code);
		f3 = 3'(rand_bits(3));
		if ((op == op_br) && (f3[2:1] == 2'b01)) begin
			f3[2] = 1'b1;
		end
		if ((op == op_csr) && (f3[1:0] == 2'b00)) begin
			f3[0] = 1'b1;
		end
		alt = 1'(rand_bits(1));
		pc  = {30'(rand_bits(30)), 2'b00};
		imm = rand_operand();
		a   = rand_operand();
		b   = (rand_bits(2) == 32'd0) ? a : rand_operand();
		rd  = 5'(rand_bits(5));
		wbk = 1'(rand_bits(1));
		sel = 3'(rand_bits(3));
		case (sel)
			3'd0: adr = rv_ex_pkg::mstatus;
			3'd1: adr = rv_ex_pkg::mie;
			3'd2: adr = rv_ex_pkg::mtvec;
			3'd3: adr = rv_ex_pkg::mscratch;
			3'd4: adr = rv_ex_pkg::mepc;
			3'd5: adr = rv_ex_pkg::mcause;
			3'd6: adr = rv_ex_pkg::mhartid;
			default: adr = 12'h7c0 | 12'(rand_bits(4));
		endcase
		uimm = (rand_bits(2) == 32'd0) ? 5'd0 : 5'(rand_bits(5));
		issue_instr(v, op, f3, alt, pc, imm, a, b, rd, wbk, adr, uimm);
	endtask

	initial begin
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		$display("timeout: the test sequence did not finish in %0d cycles", TIMEOUT_CYCLES);
		$display("Regression failed");
		$finish;
	end

	initial begin
		rst_n        = 1'b0;
		ex_valid     = 1'b0;
		op_ex        = op_alu;
		funct3_ex    = 3'd0;
		alt_ex       = 1'b0;
		pc_ex        = 32'd0;
		imm_ex       = 32'd0;
		rs1_data_ex  = 32'd0;
		rs2_data_ex  = 32'd0;
		rd_adr_ex    = 5'd0;
		wbk_rd_ex    = 1'b0;
		csr_adr_ex   = 12'd0;
		csr_uimm_ex  = 5'd0;
		ref_mie_bit  = 1'b0;
		ref_mpie_bit = 1'b0;
		ref_mie      = 32'd0;
		ref_mtvec    = `RV_EX_MTVEC_RESET;
		ref_mscratch = 32'd0;
		ref_mepc     = 32'd0;
		ref_mcause   = 32'd0;
		exp_strobe   = 1'b0;
		exp_ld       = 1'b0;
		exp_st       = 1'b0;
		exp_wbk      = 1'b0;
		exp_rd_chk   = 1'b0;
		exp_rd_adr   = 5'd0;
		exp_rd_data  = 32'd0;
		exp_st_data  = 32'd0;
		exp_code     = 3'd0;
		repeat (RESET_CYCLES) begin
			@(negedge clk);
			check_registered();
		end
		rst_n = 1'b1;
		run_trap_sequence();
		for (int i = 0; i < NUM_OPS; i++) begin
			random_instr();
		end
		@(negedge clk);
		check_registered();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule
